// File: Bender.yml
package:
  name: dm_csrs

sources:
  - logic/dm_pkg.sv
  - logic/dm_ctrl_regs.sv
  - logic/dm_abstract_regs.sv
  - logic/dm_resp_fifo.sv
  - logic/dm_csrs_top.sv
  - target: simulation
    include_dirs:
      - testbench
    files:
      - testbench/tb_dm_csrs.sv

// File: logic/dm_abstract_regs.sv
/*
 * Abstract command registers: command launch, sticky cmderr in
 * abstractcs and the data registers with hart-side bulk update.
 */
`timescale 1ns/1ns
`default_nettype none

module dm_abstract_regs #(
  parameter int unsigned DataCount = 2
) (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                                          dmactive_i,
  input  wire logic                                          cmd_we_i,
  input  wire logic                                          abscs_we_i,
  input  wire logic                                          data_we_i,
  input  wire logic                                          data_re_i,
  input  wire logic [3:0]                                    data_idx_i,
  input  wire logic [dm_pkg::WordWidth-1:0]                  wdata_i,
  input  wire logic                                          cmdbusy_i,
  input  wire logic                                          cmderror_valid_i,
  input  wire dm_pkg::cmderr_e                               cmderror_i,
  input  wire logic [DataCount-1:0][dm_pkg::WordWidth-1:0]   data_i,
  input  wire logic                                          data_valid_i,
  output logic [dm_pkg::WordWidth-1:0]                       abscs_rdata_o,
  output logic [dm_pkg::WordWidth-1:0]                       data_rdata_o,
  output logic                                               cmd_valid_o,
  output logic [dm_pkg::WordWidth-1:0]                       cmd_o,
  output logic [DataCount-1:0][dm_pkg::WordWidth-1:0]        data_o
);
  import dm_pkg::*;

  cmderr_e                             cmderr_q, cmderr_d;
  logic [WordWidth-1:0]                command_q, command_d;
  logic                                cmd_valid_q, cmd_valid_d;
  logic [DataCount-1:0][WordWidth-1:0] data_q, data_d;
  logic                                busy;

  // a command launched last cycle counts as busy until the hart reports
  assign busy = cmdbusy_i | cmd_valid_q;

  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    data_d      = data_q;
    if (busy) begin
      if ((cmd_we_i || abscs_we_i || data_we_i) && cmderr_q == CmdErrNone) begin
        cmderr_d = CmdErrBusy;
      end
    end else begin
      if (cmd_we_i) begin
        cmd_valid_d = 1'b1;
        command_d   = wdata_i;
      end
      // cmderr is write-one-to-clear
      if (abscs_we_i) begin
        cmderr_d = cmderr_e'(cmderr_q & ~wdata_i[10:8]);
      end
      if (data_we_i) begin
        data_d[data_idx_i] = wdata_i;
      end
    end
    // hart error wins over the debugger
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  assign abscs_rdata_o = {19'b0, busy, 1'b0, cmderr_q, 4'b0, 4'(DataCount)};
  assign data_rdata_o  = data_re_i ? data_q[data_idx_i] : '0;
  assign cmd_valid_o   = cmd_valid_q;
  assign cmd_o         = command_q;
  assign data_o        = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      command_q   <= '0;
      cmd_valid_q <= 1'b0;
      data_q      <= '0;
    end else begin
      cmderr_q    <= cmderr_d;
      command_q   <= command_d;
      cmd_valid_q <= cmd_valid_d;
      data_q      <= data_d;
    end
  end

  a_cmd_valid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    cmd_valid_o |=> !cmd_valid_o)
    else $error("cmd_valid_o high for two cycles");

endmodule

`default_nettype wire

// File: logic/dm_csrs_top.sv
/*
 * Debug module register block top level: control registers, abstract
 * command registers and the DMI response queue.
 */
`timescale 1ns/1ns
`default_nettype none

module dm_csrs_top #(
  parameter int unsigned NrHarts   = 4,
  parameter int unsigned DataCount = 2
) (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  // DMI request
  input  wire logic                                          dmi_req_valid_i,
  output logic                                               dmi_req_ready_o,
  input  wire dm_pkg::dtm_op_e                               dmi_req_op_i,
  input  wire logic [dm_pkg::AddrWidth-1:0]                  dmi_req_addr_i,
  input  wire logic [dm_pkg::WordWidth-1:0]                  dmi_req_data_i,
  // DMI response
  input  wire logic                                          dmi_resp_ready_i,
  output logic                                               dmi_resp_valid_o,
  output logic [dm_pkg::WordWidth-1:0]                       dmi_resp_data_o,
  // hart status and control
  input  wire logic [NrHarts-1:0]                            halted_i,
  input  wire logic [NrHarts-1:0]                            unavailable_i,
  input  wire logic [NrHarts-1:0]                            resumeack_i,
  output logic [NrHarts-1:0]                                 haltreq_o,
  output logic [NrHarts-1:0]                                 resumereq_o,
  output logic                                               clear_resumeack_o,
  output logic                                               ndmreset_o,
  output logic                                               dmactive_o,
  // abstract command
  output logic                                               cmd_valid_o,
  output logic [dm_pkg::WordWidth-1:0]                       cmd_o,
  input  wire logic                                          cmdbusy_i,
  input  wire logic                                          cmderror_valid_i,
  input  wire dm_pkg::cmderr_e                               cmderror_i,
  // data registers
  output logic [DataCount-1:0][dm_pkg::WordWidth-1:0]        data_o,
  input  wire logic [DataCount-1:0][dm_pkg::WordWidth-1:0]   data_i,
  input  wire logic                                          data_valid_i
);
  import dm_pkg::*;

  logic                 cmd_we, abscs_we, data_we, data_re;
  logic [3:0]           data_idx;
  logic [WordWidth-1:0] wdata, abscs_rdata, data_rdata, resp_word;
  logic                 resp_push, fifo_ready;

  dm_ctrl_regs #(
    .NrHarts   (NrHarts),
    .DataCount (DataCount)
  ) i_ctrl_regs (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .dmi_req_valid_i   (dmi_req_valid_i),
    .dmi_req_ready_o   (dmi_req_ready_o),
    .dmi_req_op_i      (dmi_req_op_i),
    .dmi_req_addr_i    (dmi_req_addr_i),
    .dmi_req_data_i    (dmi_req_data_i),
    .halted_i          (halted_i),
    .unavailable_i     (unavailable_i),
    .resumeack_i       (resumeack_i),
    .haltreq_o         (haltreq_o),
    .resumereq_o       (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o),
    .dmactive_o        (dmactive_o),
    .ndmreset_o        (ndmreset_o),
    .cmd_we_o          (cmd_we),
    .abscs_we_o        (abscs_we),
    .data_we_o         (data_we),
    .data_re_o         (data_re),
    .data_idx_o        (data_idx),
    .wdata_o           (wdata),
    .abscs_rdata_i     (abscs_rdata),
    .data_rdata_i      (data_rdata),
    .resp_push_o       (resp_push),
    .resp_word_o       (resp_word),
    .fifo_ready_i      (fifo_ready)
  );

  dm_abstract_regs #(
    .DataCount (DataCount)
  ) i_abstract_regs (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .dmactive_i       (dmactive_o),
    .cmd_we_i         (cmd_we),
    .abscs_we_i       (abscs_we),
    .data_we_i        (data_we),
    .data_re_i        (data_re),
    .data_idx_i       (data_idx),
    .wdata_i          (wdata),
    .cmdbusy_i        (cmdbusy_i),
    .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i       (cmderror_i),
    .data_i           (data_i),
    .data_valid_i     (data_valid_i),
    .abscs_rdata_o    (abscs_rdata),
    .data_rdata_o     (data_rdata),
    .cmd_valid_o      (cmd_valid_o),
    .cmd_o            (cmd_o),
    .data_o           (data_o)
  );

  dm_resp_fifo i_resp_fifo (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .push_i      (resp_push),
    .wdata_i     (resp_word),
    .ready_o     (fifo_ready),
    .valid_o     (dmi_resp_valid_o),
    .rdata_o     (dmi_resp_data_o),
    .pop_ready_i (dmi_resp_ready_i)
  );

endmodule

`default_nettype wire

// File: logic/dm_ctrl_regs.sv
/*
 * Debug module control registers: DMI request decode, dmcontrol,
 * dmstatus, per-hart havereset flags and response word selection.
 */
`timescale 1ns/1ns
`default_nettype none

module dm_ctrl_regs #(
  parameter int unsigned NrHarts   = 4,
  parameter int unsigned DataCount = 2
) (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          dmi_req_valid_i,
  output logic                               dmi_req_ready_o,
  input  wire dm_pkg::dtm_op_e               dmi_req_op_i,
  input  wire logic [dm_pkg::AddrWidth-1:0]  dmi_req_addr_i,
  input  wire logic [dm_pkg::WordWidth-1:0]  dmi_req_data_i,
  input  wire logic [NrHarts-1:0]            halted_i,
  input  wire logic [NrHarts-1:0]            unavailable_i,
  input  wire logic [NrHarts-1:0]            resumeack_i,
  output logic [NrHarts-1:0]                 haltreq_o,
  output logic [NrHarts-1:0]                 resumereq_o,
  output logic                               clear_resumeack_o,
  output logic                               dmactive_o,
  output logic                               ndmreset_o,
  output logic                               cmd_we_o,
  output logic                               abscs_we_o,
  output logic                               data_we_o,
  output logic                               data_re_o,
  output logic [3:0]                         data_idx_o,
  output logic [dm_pkg::WordWidth-1:0]       wdata_o,
  input  wire logic [dm_pkg::WordWidth-1:0]  abscs_rdata_i,
  input  wire logic [dm_pkg::WordWidth-1:0]  data_rdata_i,
  output logic                               resp_push_o,
  output logic [dm_pkg::WordWidth-1:0]       resp_word_o,
  input  wire logic                          fifo_ready_i
);
  import dm_pkg::*;

  logic                 req_acc, req_rd, req_wr, is_data, dmc_we;
  logic [AddrWidth-1:0] data_off;
  logic                 haltreq_q, haltreq_d, resumereq_q, resumereq_d;
  logic                 ndmreset_q, ndmreset_d, dmactive_q, dmactive_d;
  logic [9:0]           hartsel_q, hartsel_d;
  logic [NrHarts-1:0]   havereset_q, havereset_d, hart_sel;
  logic [WordWidth-1:0] dmcontrol, dmstatus, rdata;

  // ------------------------------
  // request decode
  // ------------------------------
  assign dmi_req_ready_o = fifo_ready_i;
  assign req_acc  = dmi_req_valid_i & fifo_ready_i;
  assign req_rd   = req_acc & (dmi_req_op_i == DTM_READ);
  assign req_wr   = req_acc & (dmi_req_op_i == DTM_WRITE);
  assign data_off = dmi_req_addr_i - Data0;
  assign is_data  = (dmi_req_addr_i >= Data0) && (data_off < DataCount);

  assign dmc_we     = req_wr & (dmi_req_addr_i == DMControl);
  assign cmd_we_o   = req_wr & (dmi_req_addr_i == Command);
  assign abscs_we_o = req_wr & (dmi_req_addr_i == AbstractCS);
  assign data_we_o  = req_wr & is_data;
  assign data_re_o  = req_rd & is_data;
  assign data_idx_o = data_off[3:0];
  assign wdata_o    = dmi_req_data_i;

  // one-hot hart select, all zero when out of range
  always_comb begin
    for (int unsigned h = 0; h < NrHarts; h++) begin
      hart_sel[h] = (hartsel_q == 10'(h));
    end
  end

  assign haltreq_o   = hart_sel & {NrHarts{haltreq_q}};
  assign resumereq_o = hart_sel & {NrHarts{resumereq_q}};
  assign dmactive_o  = dmactive_q;
  assign ndmreset_o  = ndmreset_q;

  always_comb begin
    haltreq_d   = haltreq_q;
    resumereq_d = resumereq_q;
    hartsel_d   = hartsel_q;
    ndmreset_d  = ndmreset_q;
    dmactive_d  = dmactive_q;
    havereset_d = havereset_q;
    if (dmc_we) begin
      haltreq_d   = dmi_req_data_i[DmcHaltreq];
      resumereq_d = dmi_req_data_i[DmcResumereq];
      hartsel_d   = dmi_req_data_i[DmcHartselLo +: 10];
      ndmreset_d  = dmi_req_data_i[DmcNdmreset];
      dmactive_d  = dmi_req_data_i[DmcDmactive];
      if (dmi_req_data_i[DmcAckhavereset]) begin
        havereset_d = havereset_q & ~hart_sel;
      end
    end
    // selected hart acknowledged the resume
    if (resumereq_q && |(hart_sel & resumeack_i)) begin
      resumereq_d = 1'b0;
    end
    if (ndmreset_q) begin
      havereset_d = '1;
    end
  end

  assign clear_resumeack_o = dmactive_q & ~resumereq_q & resumereq_d;

  // ------------------------------
  // read data
  // ------------------------------
  always_comb begin
    dmcontrol = '0;
    dmcontrol[DmcHaltreq]             = haltreq_q;
    dmcontrol[DmcResumereq]           = resumereq_q;
    dmcontrol[DmcHartselLo +: 10]     = hartsel_q;
    dmcontrol[DmcNdmreset]            = ndmreset_q;
    dmcontrol[DmcDmactive]            = dmactive_q;

    dmstatus = '0;
    dmstatus[3:0]                     = DbgVersion013;
    dmstatus[DmsAuthenticated]        = 1'b1;
    dmstatus[DmsAllhavereset]         = |(hart_sel & havereset_q);
    dmstatus[DmsAnyhavereset]         = |(hart_sel & havereset_q);
    dmstatus[DmsAllresumeack]         = |(hart_sel & resumeack_i);
    dmstatus[DmsAnyresumeack]         = |(hart_sel & resumeack_i);
    dmstatus[DmsAllnonexistent]       = ~|hart_sel;
    dmstatus[DmsAnynonexistent]       = ~|hart_sel;
    dmstatus[DmsAllunavail]           = |(hart_sel & unavailable_i);
    dmstatus[DmsAnyunavail]           = |(hart_sel & unavailable_i);
    // halted and running exclude unavailable harts
    dmstatus[DmsAllrunning]           = |(hart_sel & ~halted_i & ~unavailable_i);
    dmstatus[DmsAnyrunning]           = |(hart_sel & ~halted_i & ~unavailable_i);
    dmstatus[DmsAllhalted]            = |(hart_sel & halted_i & ~unavailable_i);
    dmstatus[DmsAnyhalted]            = |(hart_sel & halted_i & ~unavailable_i);

    rdata = '0;
    if (is_data) begin
      rdata = data_rdata_i;
    end else begin
      case (dm_csr_e'(dmi_req_addr_i))
        DMControl:  rdata = dmcontrol;
        DMStatus:   rdata = dmstatus;
        AbstractCS: rdata = abscs_rdata_i;
        default:    rdata = '0;
      endcase
    end
  end

  // writes and nops answer with zero
  assign resp_word_o = req_rd ? rdata : '0;
  assign resp_push_o = req_acc;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      haltreq_q   <= 1'b0;
      resumereq_q <= 1'b0;
      hartsel_q   <= '0;
      ndmreset_q  <= 1'b0;
      dmactive_q  <= 1'b0;
      havereset_q <= '1;
    end else begin
      havereset_q <= havereset_d;
      dmactive_q  <= dmactive_d;
      // inactive module keeps everything but dmactive cleared
      if (!dmactive_q) begin
        haltreq_q   <= 1'b0;
        resumereq_q <= 1'b0;
        hartsel_q   <= '0;
        ndmreset_q  <= 1'b0;
      end else begin
        haltreq_q   <= haltreq_d;
        resumereq_q <= resumereq_d;
        hartsel_q   <= hartsel_d;
        ndmreset_q  <= ndmreset_d;
      end
    end
  end

  a_haltreq_onehot: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0(haltreq_o))
    else $error("more than one haltreq bit set: %h", haltreq_o);

  a_clear_resumeack_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    clear_resumeack_o |=> !clear_resumeack_o)
    else $error("clear_resumeack_o high for two cycles");

endmodule

`default_nettype wire

// File: logic/dm_pkg.sv
/*
 * Debug module shared definitions: DMI widths, register addresses,
 * request operations, command errors and register field positions.
 */
`default_nettype none

package dm_pkg;

  // ------------------------------
  // DMI transport
  // ------------------------------
  localparam int unsigned WordWidth = 32;
  localparam int unsigned AddrWidth = 7;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  // register map, data registers follow Data0
  typedef enum logic [6:0] {
    Data0      = 7'h04,
    DMControl  = 7'h10,
    DMStatus   = 7'h11,
    AbstractCS = 7'h16,
    Command    = 7'h17
  } dm_csr_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'd0,
    CmdErrBusy         = 3'd1,
    CmdErrNotSupported = 3'd2,
    CmdErrException    = 3'd3,
    CmdErrHaltResume   = 3'd4,
    CmdErrBus          = 3'd5,
    CmdErrOther        = 3'd7
  } cmderr_e;

  localparam logic [3:0] DbgVersion013 = 4'h2;

  // ------------------------------
  // dmcontrol fields
  // ------------------------------
  localparam int unsigned DmcHaltreq      = 31;
  localparam int unsigned DmcResumereq    = 30;
  localparam int unsigned DmcAckhavereset = 28;
  // low bit of the 10-bit hartsello field
  localparam int unsigned DmcHartselLo    = 16;
  localparam int unsigned DmcNdmreset     = 1;
  localparam int unsigned DmcDmactive     = 0;

  // ------------------------------
  // dmstatus fields
  // ------------------------------
  localparam int unsigned DmsAllhavereset   = 19;
  localparam int unsigned DmsAnyhavereset   = 18;
  localparam int unsigned DmsAllresumeack   = 17;
  localparam int unsigned DmsAnyresumeack   = 16;
  localparam int unsigned DmsAllnonexistent = 15;
  localparam int unsigned DmsAnynonexistent = 14;
  localparam int unsigned DmsAllunavail     = 13;
  localparam int unsigned DmsAnyunavail     = 12;
  localparam int unsigned DmsAllrunning     = 11;
  localparam int unsigned DmsAnyrunning     = 10;
  localparam int unsigned DmsAllhalted      = 9;
  localparam int unsigned DmsAnyhalted      = 8;
  localparam int unsigned DmsAuthenticated  = 7;

endpackage

`default_nettype wire

// File: logic/dm_resp_fifo.sv
/*
 * Two-entry DMI response queue with valid/ready on both sides.
 */
`timescale 1ns/1ns
`default_nettype none

module dm_resp_fifo (
  input  wire logic                          clk_i,
  input  wire logic                          rst_ni,
  input  wire logic                          push_i,
  input  wire logic [dm_pkg::WordWidth-1:0]  wdata_i,
  output logic                               ready_o,
  output logic                               valid_o,
  output logic [dm_pkg::WordWidth-1:0]       rdata_o,
  input  wire logic                          pop_ready_i
);
  import dm_pkg::*;

  logic [1:0][WordWidth-1:0] mem_q;
  logic                      wr_ptr_q, rd_ptr_q;
  logic [1:0]                count_q;
  logic                      pop;

  assign ready_o = (count_q != 2'd2);
  assign valid_o = (count_q != 2'd0);
  assign rdata_o = mem_q[rd_ptr_q];
  assign pop     = valid_o & pop_ready_i;

  // ------------------------------
  // pointers and fill count
  // ------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_ptr_q <= 1'b0;
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ~wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push_i) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_q[wr_ptr_q] <= wdata_i;
    end
  end

  a_no_push_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    push_i |-> ready_o)
    else $error("push into full response queue");

  a_rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !pop_ready_i |=> valid_o && $stable(rdata_o))
    else $error("response data changed while stalled");

endmodule

`default_nettype wire

// File: sim.f
+incdir+testbench
logic/dm_pkg.sv
logic/dm_ctrl_regs.sv
logic/dm_abstract_regs.sv
logic/dm_resp_fifo.sv
logic/dm_csrs_top.sv
testbench/tb_dm_csrs.sv

// File: testbench/tb_dm_vectors.svh
/*
 * DMI request table for the register block testbench, one entry per request.
 */
// hart_inputs columns: halted, unavailable, resumeack, cmdbusy
// push_entry columns: op, address, write data, response, haltreq_o, resumereq_o

task automatic build_table();
  // ------------------------------
  // reset and inactive module
  // ------------------------------
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_READ,  DMControl, 32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_WRITE, DMControl, 32'hC002_0003, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  DMControl, 32'h0000_0000, 32'h0000_0001, 4'h0, 4'h0);
  // hart 2 selected with haltreq
  push_entry(DTM_WRITE, DMControl, 32'h8002_0001, 32'h0000_0000, 4'h4, 4'h0);
  push_entry(DTM_READ,  DMControl, 32'h0000_0000, 32'h8002_0001, 4'h4, 4'h0);

  // ------------------------------
  // dmstatus and havereset
  // ------------------------------
  hart_inputs(4'h4, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_READ,  DMStatus,  32'h0000_0000, status_word(2, 1'b1), 4'h4, 4'h0);
  hart_inputs(4'h4, 4'h4, 4'h0, 1'b0);
  push_entry(DTM_READ,  DMStatus,  32'h0000_0000, status_word(2, 1'b1), 4'h4, 4'h0);
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_READ,  DMStatus,  32'h0000_0000, status_word(2, 1'b1), 4'h4, 4'h0);
  // ackhavereset for hart 2
  push_entry(DTM_WRITE, DMControl, 32'h9002_0001, 32'h0000_0000, 4'h4, 4'h0);
  hart_inputs(4'h4, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_READ,  DMStatus,  32'h0000_0000, status_word(2, 1'b0), 4'h4, 4'h0);
  // resume handshake on hart 2
  push_entry(DTM_WRITE, DMControl, 32'h4002_0001, 32'h0000_0000, 4'h0, 4'h4);
  hart_inputs(4'h4, 4'h0, 4'h4, 1'b0);
  push_entry(DTM_READ,  DMStatus,  32'h0000_0000, status_word(2, 1'b0), 4'h0, 4'h0);
  push_entry(DTM_READ,  DMControl, 32'h0000_0000, 32'h0002_0001, 4'h0, 4'h0);
  // hart 5 does not exist
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_WRITE, DMControl, 32'h8005_0001, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  DMStatus,  32'h0000_0000, status_word(5, 1'b0), 4'h0, 4'h0);
  push_entry(DTM_READ,  DMControl, 32'h0000_0000, 32'h8005_0001, 4'h0, 4'h0);
  push_entry(DTM_WRITE, DMControl, 32'h0000_0001, 32'h0000_0000, 4'h0, 4'h0);

  // ------------------------------
  // abstract commands
  // ------------------------------
  push_entry(DTM_WRITE, Command,    32'h0022_1002, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_NOP,   7'h00,      32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  AbstractCS, 32'h0000_0000, 32'h0000_0002, 4'h0, 4'h0);
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b1);
  push_entry(DTM_WRITE, Command,    32'h0033_0000, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  AbstractCS, 32'h0000_0000, 32'h0000_1102, 4'h0, 4'h0);
  push_entry(DTM_WRITE, 7'h04,      32'hDEAD_BEEF, 32'h0000_0000, 4'h0, 4'h0);
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_READ,  AbstractCS, 32'h0000_0000, 32'h0000_0102, 4'h0, 4'h0);
  push_entry(DTM_WRITE, AbstractCS, 32'h0000_0700, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  AbstractCS, 32'h0000_0000, 32'h0000_0002, 4'h0, 4'h0);
  // data registers
  push_entry(DTM_WRITE, 7'h04,      32'h1234_5678, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_WRITE, 7'h05,      32'h9ABC_DEF0, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  7'h04,      32'h0000_0000, 32'h1234_5678, 4'h0, 4'h0);
  push_entry(DTM_READ,  7'h05,      32'h0000_0000, 32'h9ABC_DEF0, 4'h0, 4'h0);
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b1);
  push_entry(DTM_WRITE, 7'h05,      32'h5555_AAAA, 32'h0000_0000, 4'h0, 4'h0);
  hart_inputs(4'h0, 4'h0, 4'h0, 1'b0);
  push_entry(DTM_READ,  7'h05,      32'h0000_0000, 32'h9ABC_DEF0, 4'h0, 4'h0);
  data_load_entry();
  push_entry(DTM_READ,  7'h04,      32'h0000_0000, load_word0,    4'h0, 4'h0);
  push_entry(DTM_READ,  7'h05,      32'h0000_0000, load_word1,    4'h0, 4'h0);
  push_entry(DTM_WRITE, AbstractCS, 32'h0000_0700, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  AbstractCS, 32'h0000_0000, 32'h0000_0002, 4'h0, 4'h0);
  // unmapped address, then deactivate
  push_entry(DTM_READ,  7'h30,      32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_WRITE, DMControl,  32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
  push_entry(DTM_READ,  DMControl,  32'h0000_0000, 32'h0000_0000, 4'h0, 4'h0);
endtask

// File: testbench/tb_dm_csrs.sv
/*
 * Testbench for the debug module register block: applies a DMI request
 * table, models the hart side and checks responses in order.
 */
`timescale 1ns/1ns
`default_nettype none

module tb_dm_csrs;
  import dm_pkg::*;

  localparam int unsigned NrHarts   = 4;
  localparam int unsigned DataCount = 2;
  localparam logic [31:0] load_word0 = 32'hA5A5_0001;
  localparam logic [31:0] load_word1 = 32'h5A5A_0002;

  typedef struct packed {
    dtm_op_e     op;
    logic [6:0]  addr;
    logic [31:0] wdata;
    logic        busy;
    logic [3:0]  halted;
    logic [3:0]  unavail;
    logic [3:0]  rack;
    logic        load;
    logic        cmd;
    logic [31:0] resp;
    logic [3:0]  halt;
    logic [3:0]  resume;
  } entry_t;

  logic                                clk_i, rst_ni;
  logic                                dmi_req_valid_i, dmi_req_ready_o;
  dtm_op_e                             dmi_req_op_i;
  logic [AddrWidth-1:0]                dmi_req_addr_i;
  logic [WordWidth-1:0]                dmi_req_data_i, dmi_resp_data_o, cmd_o;
  logic                                dmi_resp_ready_i, dmi_resp_valid_o;
  logic [NrHarts-1:0]                  halted_i, unavailable_i, resumeack_i;
  logic [NrHarts-1:0]                  haltreq_o, resumereq_o;
  logic                                clear_resumeack_o, ndmreset_o, dmactive_o;
  logic                                cmd_valid_o, cmdbusy_i, cmderror_valid_i;
  cmderr_e                             cmderror_i;
  logic [DataCount-1:0][WordWidth-1:0] data_o, data_i;
  logic                                data_valid_i;

  entry_t      vecs[$];
  logic [31:0] exp_resp[$];
  logic [31:0] exp_cmd[$];
  int          errors = 0;
  int          accepted = 0;
  int          popped = 0;
  int          cycles = 0;
  int          limit = 1000;
  integer      seed = 32'h791f_f93c;
  // hart side state while the table is built
  logic [3:0]  cur_halted, cur_unavail, cur_rack;
  logic        cur_busy, cur_load;

  dm_csrs_top #(
    .NrHarts   (NrHarts),
    .DataCount (DataCount)
  ) UUT (
    .clk_i (clk_i), .rst_ni (rst_ni),
    .dmi_req_valid_i (dmi_req_valid_i), .dmi_req_ready_o (dmi_req_ready_o),
    .dmi_req_op_i (dmi_req_op_i), .dmi_req_addr_i (dmi_req_addr_i),
    .dmi_req_data_i (dmi_req_data_i), .dmi_resp_ready_i (dmi_resp_ready_i),
    .dmi_resp_valid_o (dmi_resp_valid_o), .dmi_resp_data_o (dmi_resp_data_o),
    .halted_i (halted_i), .unavailable_i (unavailable_i), .resumeack_i (resumeack_i),
    .haltreq_o (haltreq_o), .resumereq_o (resumereq_o),
    .clear_resumeack_o (clear_resumeack_o), .ndmreset_o (ndmreset_o),
    .dmactive_o (dmactive_o), .cmd_valid_o (cmd_valid_o), .cmd_o (cmd_o),
    .cmdbusy_i (cmdbusy_i), .cmderror_valid_i (cmderror_valid_i),
    .cmderror_i (cmderror_i), .data_o (data_o), .data_i (data_i),
    .data_valid_i (data_valid_i)
  );

  task automatic expect_eq(input string name, input logic [31:0] got,
                           input logic [31:0] want);
    assert (got === want) else begin
      errors++;
      $display("error: %s = %h, expected %h", name, got, want);
    end
  endtask

  task automatic hart_inputs(input logic [3:0] halted, input logic [3:0] unavail,
                             input logic [3:0] rack, input logic busy);
    cur_halted  = halted;
    cur_unavail = unavail;
    cur_rack    = rack;
    cur_busy    = busy;
  endtask

  task automatic push_entry(input dtm_op_e op, input logic [6:0] addr,
                            input logic [31:0] wdata, input logic [31:0] resp,
                            input logic [3:0] halt, input logic [3:0] resume);
    entry_t e;
    e = '{op, addr, wdata, cur_busy, cur_halted, cur_unavail, cur_rack, cur_load,
          1'b0, resp, halt, resume};
    // a command write launches only when the hart is idle
    e.cmd = (op == DTM_WRITE) && (addr == Command) && !cur_busy;
    vecs.push_back(e);
  endtask

  task automatic data_load_entry();
    cur_load = 1'b1;
    push_entry(DTM_NOP, 7'h00, 32'h0, 32'h0, 4'h0, 4'h0);
    cur_load = 1'b0;
  endtask

  // expected dmstatus for one selected hart, from the field definitions
  function automatic logic [31:0] status_word(input int unsigned hart, input logic hrst);
    logic [31:0] w;
    logic        h, u, r;
    w = 32'h0000_0082;
    if (hart >= NrHarts) begin
      w[15:14] = 2'b11;
    end else begin
      h = cur_halted[hart];
      u = cur_unavail[hart];
      r = cur_rack[hart];
      w[19:18] = {2{hrst}};
      w[17:16] = {2{r}};
      w[13:12] = {2{u}};
      w[11:10] = {2{~h & ~u}};
      w[9:8]   = {2{h & ~u}};
    end
    return w;
  endfunction

  `include "tb_dm_vectors.svh"

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // ------------------------------
  // request driver
  // ------------------------------
  initial begin : stimulus
    entry_t e;
    rst_ni = 1'b0;
    dmi_req_valid_i = 1'b0;
    dmi_req_op_i = DTM_NOP;
    dmi_req_addr_i = '0;
    dmi_req_data_i = '0;
    dmi_resp_ready_i = 1'b0;
    halted_i = '0;
    unavailable_i = '0;
    resumeack_i = '0;
    cmdbusy_i = 1'b0;
    cmderror_valid_i = 1'b0;
    cmderror_i = CmdErrNone;
    data_i = {load_word1, load_word0};
    data_valid_i = 1'b0;
    cur_load = 1'b0;
    hart_inputs(4'h0, 4'h0, 4'h0, 1'b0);
    build_table();
    limit = 8 * vecs.size() + 100;
    repeat (16) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    expect_eq("dmi_req_ready_o", dmi_req_ready_o, 1);
    expect_eq("dmi_resp_valid_o", dmi_resp_valid_o, 0);
    expect_eq("cmd_valid_o", cmd_valid_o, 0);
    expect_eq("haltreq_o", haltreq_o, 0);
    expect_eq("resumereq_o", resumereq_o, 0);
    expect_eq("ndmreset_o", ndmreset_o, 0);
    expect_eq("dmactive_o", dmactive_o, 0);
    expect_eq("clear_resumeack_o", clear_resumeack_o, 0);
    for (int i = 0; i < vecs.size(); i++) begin
      e = vecs[i];
      dmi_req_valid_i = 1'b1;
      dmi_req_op_i = e.op;
      dmi_req_addr_i = e.addr;
      dmi_req_data_i = e.wdata;
      cmdbusy_i = e.busy;
      halted_i = e.halted;
      unavailable_i = e.unavail;
      resumeack_i = e.rack;
      data_valid_i = e.load;
      // ready only moves on the rising edge
      while (!dmi_req_ready_o) @(negedge clk_i);
      @(posedge clk_i);
      exp_resp.push_back(e.resp);
      if (e.cmd) begin
        exp_cmd.push_back(e.wdata);
      end
      accepted++;
      @(negedge clk_i);
      dmi_req_valid_i = 1'b0;
      data_valid_i = 1'b0;
      expect_eq("haltreq_o", haltreq_o, e.halt);
      expect_eq("resumereq_o", resumereq_o, e.resume);
      if (e.load) begin
        expect_eq("data_o[0]", data_o[0], load_word0);
        expect_eq("data_o[1]", data_o[1], load_word1);
      end
    end
    while (exp_resp.size() != 0) @(negedge clk_i);
    repeat (2) @(negedge clk_i);
    assert (exp_cmd.size() == 0) else begin
      errors++;
      $display("missing cmd_valid_o pulse for %0d command write(s)", exp_cmd.size());
    end
    assert (popped == accepted) else begin
      errors++;
      $display("%0d responses seen for %0d accepted requests", popped, accepted);
    end
    expect_eq("dmi_resp_valid_o", dmi_resp_valid_o, 0);
    $display("errors: %0d, responses: %0d, requests: %0d", errors, popped, accepted);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

  // response collector with random stalls
  initial begin : collector
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      dmi_resp_ready_i = $random(seed) & 1;
      if (dmi_resp_ready_i && dmi_resp_valid_o) begin
        assert (exp_resp.size() != 0) else begin
          errors++;
          $display("response popped with no request outstanding");
        end
        if (exp_resp.size() != 0) begin
          expect_eq("dmi_resp_data_o", dmi_resp_data_o, exp_resp.pop_front());
        end
        popped++;
      end
    end
  end

  initial begin : cmd_monitor
    wait (rst_ni === 1'b1);
    forever begin
      @(negedge clk_i);
      if (cmd_valid_o) begin
        assert (exp_cmd.size() != 0) else begin
          errors++;
          $display("cmd_valid_o pulsed with no command write pending");
        end
        if (exp_cmd.size() != 0) begin
          expect_eq("cmd_o", cmd_o, exp_cmd.pop_front());
        end
      end
    end
  end

  initial begin : watchdog
    @(posedge clk_i);
    while (cycles < limit) begin
      @(posedge clk_i);
      cycles++;
    end
    $display("timeout: run did not finish within %0d cycles", limit);
    $display("*** TEST FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire
